/* rs_exec.f */
design/rs_exec_pkg.sv
design/issue_if.sv
design/oldest_select.sv
design/resv_station.sv
design/alu_unit.sv
design/mult_unit.sv
design/rs_exec_top.sv
testbench/rs_exec_assertions.sv
testbench/rs_exec_tb.sv

/* Bender.yml */
package:
  name: rs_exec

sources:
  - design/rs_exec_pkg.sv
  - design/issue_if.sv
  - design/oldest_select.sv
  - design/resv_station.sv
  - design/alu_unit.sv
  - design/mult_unit.sv
  - design/rs_exec_top.sv
  - target: test
    files:
      - testbench/rs_exec_assertions.sv
      - testbench/rs_exec_tb.sv

/* testbench/rs_exec_tb.sv */
`default_nettype none

module rs_exec_tb;

    localparam int RS_SIZE     = 8;
    localparam int MULT_STAGES = 3;
    localparam int HOLD_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 500;
    localparam int NUM_RANDOM  = 300;

    logic                     clock;
    logic                     reset;
    logic                     disp_valid;
    logic                     disp_ready;
    rs_exec_pkg::fu_kind_e    disp_kind;
    rs_exec_pkg::alu_func_e   disp_func;
    logic                     disp_src1_ready;
    rs_exec_pkg::word_t       disp_src1;
    logic                     disp_src2_ready;
    rs_exec_pkg::word_t       disp_src2;
    rs_exec_pkg::tag_t        disp_dest;
    logic [1:0]               cdb_valid;
    rs_exec_pkg::tag_t [1:0]  cdb_tag;
    rs_exec_pkg::word_t [1:0] cdb_value;

    // model state per tag is 0 free, 1 pending or 2 done
    logic [1:0]             state     [32];
    rs_exec_pkg::fu_kind_e  t_kind    [32];
    rs_exec_pkg::alu_func_e t_func    [32];
    logic                   known     [32][2];
    rs_exec_pkg::word_t     sval      [32][2];
    rs_exec_pkg::tag_t      stag      [32][2];
    rs_exec_pkg::word_t     tval      [32];
    logic                   timed     [32];
    int unsigned            acc_cycle [32];

    int unsigned cycle;
    int unsigned n_pending;
    logic        accepted;
    logic        saw_full;
    logic [31:0] lfsr;

    rs_exec_top #(.RS_SIZE(RS_SIZE), .MULT_STAGES(MULT_STAGES)) i_dut (.*);

    bind resv_station rs_exec_assertions #(.RS_SIZE(RS_SIZE)) i_assertions (
        .clock      (clock),
        .reset      (reset),
        .disp_ready (disp_ready),
        .entries    (entries),
        .alu_valid  (alu_issue.valid),
        .alu_dest   (alu_issue.dest_tag),
        .mult_valid (mult_issue.valid),
        .mult_dest  (mult_issue.dest_tag)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic rs_exec_pkg::tag_t alloc_tag();
        rs_exec_pkg::tag_t t;
        t = rs_exec_pkg::tag_t'(rand_bits(5));
        for (int i = 0; i < 32; i++) begin
            if (t != '0 && state[t] != 2'd1) begin
                return t;
            end
            t = t + 1'b1;
        end
        return '0;
    endfunction

    function automatic rs_exec_pkg::word_t expected(input rs_exec_pkg::tag_t t);
        logic [63:0]        prod;
        rs_exec_pkg::word_t r;
        prod = sval[t][0] * sval[t][1];
        case (t_func[t])
            rs_exec_pkg::ALU_ADD: r = sval[t][0] + sval[t][1];
            rs_exec_pkg::ALU_SUB: r = sval[t][0] - sval[t][1];
            rs_exec_pkg::ALU_AND: r = sval[t][0] & sval[t][1];
            default:              r = sval[t][0] ^ sval[t][1];
        endcase
        if (t_kind[t] == rs_exec_pkg::FU_MULT) begin
            r = prod[31:0];   // func ignored by the multiplier
        end
        return r;
    endfunction

    task automatic wake(input rs_exec_pkg::tag_t t, input rs_exec_pkg::word_t v);
        for (int i = 0; i < 32; i++) begin
            for (int j = 0; j < 2; j++) begin
                if (state[i] == 2'd1 && !known[i][j] && stag[i][j] == t) begin
                    known[i][j] = 1'b1;
                    sval[i][j]  = v;
                end
            end
        end
    endtask

    task automatic check_lane(input int l);
        rs_exec_pkg::tag_t  t;
        rs_exec_pkg::word_t exp;
        int unsigned        lat;
        t   = cdb_tag[l];
        lat = (l == 1) ? MULT_STAGES + 1 : 2;
        assert (t != '0)
            else report_failure($sformatf("Error: cdb_tag[%0d] is %h, expected a nonzero tag",
                                          l, t));
        assert (state[t] == 2'd1)
            else report_failure($sformatf("Error: cdb_tag[%0d] is %h, expected a pending tag",
                                          l, t));
        assert ((t_kind[t] == rs_exec_pkg::FU_MULT) == (l == 1))
            else report_failure($sformatf("lane %0d carried the other unit's instruction", l));
        assert (known[t][0] && known[t][1])
            else report_failure($sformatf("tag %0d finished before its operands existed", t));
        exp = expected(t);
        assert (cdb_value[l] == exp)
            else report_failure($sformatf("Error: cdb_value[%0d] is %h, expected %h (tag %h)",
                                          l, cdb_value[l], exp, t));
        if (timed[t]) begin
            assert (cycle - acc_cycle[t] == lat)
                else report_failure($sformatf("Error: cdb_valid[%0d] latency is %h, expected %h",
                                              l, cycle - acc_cycle[t], lat));
        end
        state[t] = 2'd2;
        tval[t]  = exp;
        n_pending--;
        wake(t, exp);
    endtask

    // sample at negedge and drive just after posedge
    task automatic step();
        logic acc;
        @(negedge clock);
        for (int l = 0; l < 2; l++) begin
            if (cdb_valid[l]) begin
                check_lane(l);
            end
        end
        if (!disp_ready) begin
            saw_full = 1'b1;
        end
        acc = disp_valid && disp_ready;
        @(posedge clock);
        cycle++;
        #10;
        accepted = acc;
    endtask

    // done tags are renamed to their values
    task automatic resolve(input rs_exec_pkg::tag_t t, input rs_exec_pkg::word_t v,
                           output logic k, output rs_exec_pkg::word_t a,
                           output rs_exec_pkg::tag_t s);
        k = 1'b1;
        a = v;
        s = '0;
        if (t != '0 && state[t] == 2'd1) begin
            k = 1'b0;
            s = t;
        end else if (t != '0 && state[t] == 2'd2) begin
            a = tval[t];
        end
    endtask

    task automatic create(input rs_exec_pkg::fu_kind_e k, input rs_exec_pkg::alu_func_e f,
                          input rs_exec_pkg::tag_t t1, input rs_exec_pkg::word_t v1,
                          input rs_exec_pkg::tag_t t2, input rs_exec_pkg::word_t v2,
                          output rs_exec_pkg::tag_t d);
        logic               k1;
        logic               k2;
        rs_exec_pkg::word_t a1;
        rs_exec_pkg::word_t a2;
        rs_exec_pkg::tag_t  s1;
        rs_exec_pkg::tag_t  s2;
        resolve(t1, v1, k1, a1, s1);
        resolve(t2, v2, k2, a2, s2);
        d = alloc_tag();
        assert (d != '0) else report_failure("no free tag left for a new instruction");
        state[d]   = 2'd1;
        t_kind[d]  = k;
        t_func[d]  = f;
        known[d][0] = k1;
        sval[d][0]  = a1;
        stag[d][0]  = s1;
        known[d][1] = k2;
        sval[d][1]  = a2;
        stag[d][1]  = s2;
        timed[d]   = 1'b0;
        n_pending++;
    endtask

    task automatic drive(input rs_exec_pkg::tag_t d);
        disp_valid      = 1'b1;
        disp_kind       = t_kind[d];
        disp_func       = t_func[d];
        disp_dest       = d;
        disp_src1_ready = known[d][0];
        disp_src1       = known[d][0] ? sval[d][0] : rs_exec_pkg::word_t'(stag[d][0]);
        disp_src2_ready = known[d][1];
        disp_src2       = known[d][1] ? sval[d][1] : rs_exec_pkg::word_t'(stag[d][1]);
    endtask

    task automatic dispatch(input rs_exec_pkg::tag_t d, input logic timed_now);
        int waited;
        waited   = 0;
        timed[d] = timed_now;
        drive(d);
        step();
        while (!accepted) begin
            assert (waited < HOLD_LIMIT)
                else report_failure("dispatch was not accepted within the timeout");
            drive(d);   // picks up operands woken meanwhile
            step();
            waited++;
        end
        acc_cycle[d] = cycle;
        disp_valid   = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (n_pending != 0) begin
            assert (waited < DRAIN_LIMIT)
                else report_failure("dispatched instructions did not complete within the timeout");
            step();
            waited++;
        end
    endtask

    task automatic random_source(output rs_exec_pkg::tag_t t, output rs_exec_pkg::word_t v);
        t = rs_exec_pkg::tag_t'(rand_bits(1) ? rand_bits(5) : 0);
        v = rand_bits(32);
    endtask

    initial begin
        rs_exec_pkg::tag_t  d;
        rs_exec_pkg::tag_t  p;
        rs_exec_pkg::tag_t  t1;
        rs_exec_pkg::tag_t  t2;
        rs_exec_pkg::word_t v1;
        rs_exec_pkg::word_t v2;
        reset           = 1'b1;
        disp_valid      = 1'b0;
        disp_kind       = rs_exec_pkg::FU_ALU;
        disp_func       = rs_exec_pkg::ALU_ADD;
        disp_src1_ready = 1'b0;
        disp_src1       = '0;
        disp_src2_ready = 1'b0;
        disp_src2       = '0;
        disp_dest       = '0;
        lfsr            = 32'd48;
        cycle           = 0;
        n_pending       = 0;
        saw_full        = 1'b0;
        for (int i = 0; i < 32; i++) begin
            state[i] = 2'd0;
            timed[i] = 1'b0;
        end
        repeat (10) @(posedge clock);
        #10;
        reset = 1'b0;
        assert (disp_ready === 1'b1 && cdb_valid === 2'b00)
            else report_failure("disp_ready low or a CDB lane valid after reset");

        // fixed latency into an empty station
        for (int f = 0; f < 4; f++) begin
            create(rs_exec_pkg::FU_ALU, rs_exec_pkg::alu_func_e'(f),
                   '0, rand_bits(32), '0, rand_bits(32), d);
            dispatch(d, 1'b1);
            drain();
        end
        create(rs_exec_pkg::FU_MULT, rs_exec_pkg::ALU_ADD, '0, rand_bits(32), '0, rand_bits(32), d);
        dispatch(d, 1'b1);
        drain();

        // consumer accepted on the producer's broadcast edge
        create(rs_exec_pkg::FU_ALU, rs_exec_pkg::ALU_ADD, '0, rand_bits(32), '0, rand_bits(32), p);
        dispatch(p, 1'b0);
        repeat (2) step();
        create(rs_exec_pkg::FU_ALU, rs_exec_pkg::ALU_SUB, p, '0, '0, rand_bits(32), d);
        dispatch(d, 1'b0);
        drain();
        create(rs_exec_pkg::FU_MULT, rs_exec_pkg::ALU_ADD, '0, rand_bits(32), '0, rand_bits(32), p);
        dispatch(p, 1'b0);
        repeat (MULT_STAGES + 1) step();
        create(rs_exec_pkg::FU_MULT, rs_exec_pkg::ALU_ADD, p, '0, p, '0, d);
        dispatch(d, 1'b0);
        drain();

        // mult chain keeps dependents waiting until the station fills
        saw_full = 1'b0;
        create(rs_exec_pkg::FU_MULT, rs_exec_pkg::ALU_ADD, '0, rand_bits(32), '0, rand_bits(32), p);
        dispatch(p, 1'b0);
        repeat (2) begin
            create(rs_exec_pkg::FU_MULT, rs_exec_pkg::ALU_ADD, p, '0, '0, rand_bits(32), d);
            dispatch(d, 1'b0);
            p = d;
        end
        repeat (RS_SIZE + 1) begin
            create(rs_exec_pkg::FU_ALU, rs_exec_pkg::alu_func_e'(rand_bits(2)),
                   p, '0, '0, rand_bits(32), d);
            dispatch(d, 1'b0);
        end
        drain();
        assert (saw_full) else report_failure("disp_ready never dropped with the station full");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (rand_bits(2) == 0) begin
                step();   // idle cycle
            end
            random_source(t1, v1);
            random_source(t2, v2);
            create(rs_exec_pkg::fu_kind_e'(rand_bits(1)), rs_exec_pkg::alu_func_e'(rand_bits(2)),
                   t1, v1, t2, v2, d);
            dispatch(d, 1'b0);
        end
        drain();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rs_exec_assertions.sv */
`default_nettype none

module rs_exec_assertions #(
    parameter int RS_SIZE = 8
) (
    input logic                   clock,
    input logic                   reset,
    input logic                   disp_ready,
    input rs_exec_pkg::rs_entry_t entries [RS_SIZE],
    input logic                   alu_valid,
    input rs_exec_pkg::tag_t      alu_dest,
    input logic                   mult_valid,
    input rs_exec_pkg::tag_t      mult_dest
);

    logic all_valid;

    always_comb begin
        all_valid = 1'b1;
        for (int i = 0; i < RS_SIZE; i++) begin
            all_valid = all_valid && entries[i].valid;
        end
    end

    no_issue_in_reset: assert property (@(posedge clock) reset |=> !(alu_valid || mult_valid))
        else $error("issue valid set while reset is high");

    alu_dest_nonzero: assert property (@(posedge clock) disable iff (reset)
        alu_valid |-> alu_dest != '0)
        else $error("ALU issue with dest tag 0");

    mult_dest_nonzero: assert property (@(posedge clock) disable iff (reset)
        mult_valid |-> mult_dest != '0)
        else $error("multiplier issue with dest tag 0");

    // a full station stays full until an entry issues
    full_until_issue: assert property (@(posedge clock) disable iff (reset)
        !disp_ready |=> all_valid == !(alu_valid || mult_valid))
        else $error("full station gained or lost an entry without a matching issue");

endmodule

`default_nettype wire

/* design/rs_exec_top.sv */
`default_nettype none

module rs_exec_top #(
    parameter int RS_SIZE     = rs_exec_pkg::DEF_RS_SIZE,
    parameter int MULT_STAGES = rs_exec_pkg::DEF_MULT_STAGES
) (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      disp_valid,
    output logic                      disp_ready,
    input  rs_exec_pkg::fu_kind_e     disp_kind,
    input  rs_exec_pkg::alu_func_e    disp_func,
    input  logic                      disp_src1_ready,
    input  rs_exec_pkg::word_t        disp_src1,
    input  logic                      disp_src2_ready,
    input  rs_exec_pkg::word_t        disp_src2,
    input  rs_exec_pkg::tag_t         disp_dest,

    output logic [1:0]                cdb_valid,
    output rs_exec_pkg::tag_t [1:0]   cdb_tag,
    output rs_exec_pkg::word_t [1:0]  cdb_value
);

    issue_if alu_issue ();
    issue_if mult_issue ();

    resv_station #(.RS_SIZE(RS_SIZE)) i_resv_station (
        .clock           (clock),
        .reset           (reset),
        .disp_valid      (disp_valid),
        .disp_ready      (disp_ready),
        .disp_kind       (disp_kind),
        .disp_func       (disp_func),
        .disp_src1_ready (disp_src1_ready),
        .disp_src1       (disp_src1),
        .disp_src2_ready (disp_src2_ready),
        .disp_src2       (disp_src2),
        .disp_dest       (disp_dest),
        .cdb_valid       (cdb_valid),   // fed back for wake-up
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .alu_issue       (alu_issue.issuer),
        .mult_issue      (mult_issue.issuer)
    );

    alu_unit i_alu_unit (
        .clock     (clock),
        .reset     (reset),
        .issue     (alu_issue.unit),
        .cdb_valid (cdb_valid[0]),
        .cdb_tag   (cdb_tag[0]),
        .cdb_value (cdb_value[0])
    );

    mult_unit #(.MULT_STAGES(MULT_STAGES)) i_mult_unit (
        .clock     (clock),
        .reset     (reset),
        .issue     (mult_issue.unit),
        .cdb_valid (cdb_valid[1]),
        .cdb_tag   (cdb_tag[1]),
        .cdb_value (cdb_value[1])
    );

endmodule

`default_nettype wire

/* design/mult_unit.sv */
`default_nettype none

module mult_unit #(
    parameter int MULT_STAGES = rs_exec_pkg::DEF_MULT_STAGES
) (
    input  logic                clock,
    input  logic                reset,
    issue_if.unit               issue,
    output logic                cdb_valid,
    output rs_exec_pkg::tag_t   cdb_tag,
    output rs_exec_pkg::word_t  cdb_value
);

    logic [MULT_STAGES-1:0] stage_valid;
    rs_exec_pkg::tag_t      stage_tag  [MULT_STAGES];
    rs_exec_pkg::word_t     stage_prod [MULT_STAGES];

    rs_exec_pkg::word_t product;

    assign product = issue.op1 * issue.op2;   // low 32 bits only

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue.valid;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // tag and product just ride along
    always_ff @(posedge clock) begin
        stage_tag[0]  <= issue.dest_tag;
        stage_prod[0] <= product;
        for (int s = 1; s < MULT_STAGES; s++) begin
            stage_tag[s]  <= stage_tag[s-1];
            stage_prod[s] <= stage_prod[s-1];
        end
    end

    assign cdb_valid = stage_valid[MULT_STAGES-1];
    assign cdb_tag   = stage_tag[MULT_STAGES-1];
    assign cdb_value = stage_prod[MULT_STAGES-1];

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`default_nettype none

module alu_unit (
    input  logic                clock,
    input  logic                reset,
    issue_if.unit               issue,
    output logic                cdb_valid,
    output rs_exec_pkg::tag_t   cdb_tag,
    output rs_exec_pkg::word_t  cdb_value
);

    rs_exec_pkg::word_t result;

    always_comb begin
        case (issue.func)
            rs_exec_pkg::ALU_ADD: result = issue.op1 + issue.op2;
            rs_exec_pkg::ALU_SUB: result = issue.op1 - issue.op2;
            rs_exec_pkg::ALU_AND: result = issue.op1 & issue.op2;
            default:              result = issue.op1 ^ issue.op2;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue.valid;   // lane 0, one cycle after issue
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= issue.dest_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

/* design/resv_station.sv */
`default_nettype none

module resv_station #(
    parameter int RS_SIZE = rs_exec_pkg::DEF_RS_SIZE
) (
    input  logic                      clock,
    input  logic                      reset,

    input  logic                      disp_valid,
    output logic                      disp_ready,
    input  rs_exec_pkg::fu_kind_e     disp_kind,
    input  rs_exec_pkg::alu_func_e    disp_func,
    input  logic                      disp_src1_ready,
    input  rs_exec_pkg::word_t        disp_src1,
    input  logic                      disp_src2_ready,
    input  rs_exec_pkg::word_t        disp_src2,
    input  rs_exec_pkg::tag_t         disp_dest,

    input  logic [1:0]                cdb_valid,
    input  rs_exec_pkg::tag_t [1:0]   cdb_tag,
    input  rs_exec_pkg::word_t [1:0]  cdb_value,

    issue_if.issuer                   alu_issue,
    issue_if.issuer                   mult_issue
);

    rs_exec_pkg::rs_entry_t entries      [RS_SIZE];
    rs_exec_pkg::rs_entry_t next_entries [RS_SIZE];

    logic [RS_SIZE-1:0] free_vec;
    logic [RS_SIZE-1:0] alu_req;
    logic [RS_SIZE-1:0] mult_req;
    logic [RS_SIZE-1:0] alu_gnt;
    logic [RS_SIZE-1:0] mult_gnt;

    rs_exec_pkg::rs_entry_t alu_pick;
    rs_exec_pkg::rs_entry_t mult_pick;

    logic placed;

    // one-hot grant to entry contents
    function automatic rs_exec_pkg::rs_entry_t granted(input logic [RS_SIZE-1:0] gnt);
        rs_exec_pkg::rs_entry_t e;
        e = entries[0];
        for (int i = 0; i < RS_SIZE; i++) begin
            if (gnt[i]) begin
                e = entries[i];
            end
        end
        return e;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            free_vec[i] = !entries[i].valid;
            alu_req[i]  = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                          && (entries[i].kind == rs_exec_pkg::FU_ALU);
            mult_req[i] = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                          && (entries[i].kind == rs_exec_pkg::FU_MULT);
        end
    end

    assign disp_ready = |free_vec;   // registered state only

    oldest_select #(.WIDTH(RS_SIZE)) i_alu_select (
        .req (alu_req),
        .gnt (alu_gnt)
    );

    oldest_select #(.WIDTH(RS_SIZE)) i_mult_select (
        .req (mult_req),
        .gnt (mult_gnt)
    );

    always_comb begin
        next_entries = entries;
        placed       = 1'b0;

        // insert into lowest free entry
        for (int i = 0; i < RS_SIZE; i++) begin
            if (disp_valid && disp_ready && free_vec[i] && !placed) begin
                next_entries[i].valid     = 1'b1;
                next_entries[i].kind      = disp_kind;
                next_entries[i].func      = disp_func;
                next_entries[i].op1_ready = disp_src1_ready;
                next_entries[i].op1       = disp_src1;
                next_entries[i].op2_ready = disp_src2_ready;
                next_entries[i].op2       = disp_src2;
                next_entries[i].dest_tag  = disp_dest;
                placed = 1'b1;
            end
        end

        // wake-up covers the freshly inserted entry too
        for (int i = 0; i < RS_SIZE; i++) begin
            for (int l = 0; l < 2; l++) begin
                if (cdb_valid[l]) begin
                    if (!next_entries[i].op1_ready &&
                        next_entries[i].op1[rs_exec_pkg::TAG_WIDTH-1:0] == cdb_tag[l]) begin
                        next_entries[i].op1_ready = 1'b1;
                        next_entries[i].op1       = cdb_value[l];
                    end
                    if (!next_entries[i].op2_ready &&
                        next_entries[i].op2[rs_exec_pkg::TAG_WIDTH-1:0] == cdb_tag[l]) begin
                        next_entries[i].op2_ready = 1'b1;
                        next_entries[i].op2       = cdb_value[l];
                    end
                end
            end
            if (alu_gnt[i] || mult_gnt[i]) begin
                next_entries[i].valid = 1'b0;   // freed on issue
            end
        end
    end

    always_comb begin
        alu_pick  = granted(alu_gnt);
        mult_pick = granted(mult_gnt);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= next_entries;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_issue.valid  <= 1'b0;
            mult_issue.valid <= 1'b0;
        end else begin
            alu_issue.valid  <= |alu_gnt;
            mult_issue.valid <= |mult_gnt;
        end
    end

    // issue payload, qualified by valid
    always_ff @(posedge clock) begin
        alu_issue.func      <= alu_pick.func;
        alu_issue.op1       <= alu_pick.op1;
        alu_issue.op2       <= alu_pick.op2;
        alu_issue.dest_tag  <= alu_pick.dest_tag;
        mult_issue.func     <= mult_pick.func;
        mult_issue.op1      <= mult_pick.op1;
        mult_issue.op2      <= mult_pick.op2;
        mult_issue.dest_tag <= mult_pick.dest_tag;
    end

endmodule

`default_nettype wire

/* design/oldest_select.sv */
`default_nettype none

module oldest_select #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    logic taken;

    // fixed priority, index 0 wins
    always_comb begin
        gnt   = '0;
        taken = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && !taken) begin
                gnt[i] = 1'b1;
                taken  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/issue_if.sv */
`default_nettype none

// one issued instruction, a single-cycle pulse per issue
interface issue_if;

    logic                      valid;
    rs_exec_pkg::alu_func_e    func;
    rs_exec_pkg::word_t        op1;
    rs_exec_pkg::word_t        op2;
    rs_exec_pkg::tag_t         dest_tag;

    modport issuer (
        output valid,
        output func,
        output op1,
        output op2,
        output dest_tag
    );

    modport unit (
        input valid,
        input func,
        input op1,
        input op2,
        input dest_tag
    );

endinterface

`default_nettype wire

/* design/rs_exec_pkg.sv */
`default_nettype none

package rs_exec_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int TAG_WIDTH  = 5;

    localparam int DEF_RS_SIZE     = 8;
    localparam int DEF_MULT_STAGES = 3;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // tag 0 is the "no producer" tag
    typedef logic [TAG_WIDTH-1:0] tag_t;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_kind_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_func_e;

    // op1/op2 hold a tag in the low bits until ready
    typedef struct packed {
        logic      valid;
        fu_kind_e  kind;
        alu_func_e func;
        logic      op1_ready;
        word_t     op1;
        logic      op2_ready;
        word_t     op2;
        tag_t      dest_tag;
    } rs_entry_t;

endpackage

`default_nettype wire
